/* rtl/dcachePkg.sv */
package dcachePkg;

  // byte address split, 17 bits in all
  localparam int ADDR_WIDTH       = 17;
  localparam int OFFSET_WIDTH     = 4;   // byte within block
  localparam int BLOCK_BYTES      = 16;
  localparam int LINE_WIDTH       = 128; // data bits per line
  localparam int INDEX_WIDTH      = 5;   // 32 lines
  localparam int BANK_INDEX_WIDTH = 4;   // 16 lines per bank
  localparam int TAG_WIDTH        = 8;
  localparam int BLOCK_ADDR_WIDTH = 13;  // address without offset

  // access size codes, as driven by the load/store unit
  localparam logic [1:0] ACCESS_NONE = 2'd0;
  localparam logic [1:0] ACCESS_BYTE = 2'd1;
  localparam logic [1:0] ACCESS_HALF = 2'd2;
  localparam logic [1:0] ACCESS_WORD = 2'd3;

  // lookup view
  // index bit 0 selects the even or the odd bank
  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
  } addrFieldsT;

  // miss and refill view
  typedef struct packed {
    logic [BLOCK_ADDR_WIDTH-1:0] blockAddr;
    logic [OFFSET_WIDTH-1:0]     offset;
  } addrBlockT;

  // one address word, read either way
  typedef union packed {
    addrFieldsT fields;
    addrBlockT  block;
  } dataAddrT;

endpackage

/* rtl/cacheBank.sv */
`timescale 1ns/100ps

// one bank of the direct-mapped cache
// lookup is combinational, fill and store land at the clock edge
module cacheBank
  import dcachePkg::*;
(
  input  logic                        clkIn,
  input  logic                        resetIn,
  input  logic [BANK_INDEX_WIDTH-1:0] lookupIndex,
  input  logic [TAG_WIDTH-1:0]        lookupTag,
  input  logic [BLOCK_BYTES-1:0]      storeMask,   // one bit per byte
  input  logic [LINE_WIDTH-1:0]       storeData,   // already in byte position
  input  logic                        fillValid,
  input  logic [BANK_INDEX_WIDTH-1:0] fillIndex,
  input  logic [TAG_WIDTH-1:0]        fillTag,
  input  logic [LINE_WIDTH-1:0]       fillData,
  output logic                        hit,
  output logic [LINE_WIDTH-1:0]       lineData
);

  logic [2**BANK_INDEX_WIDTH-1:0] validBits;
  logic [TAG_WIDTH-1:0]           tagMem  [2**BANK_INDEX_WIDTH];
  logic [LINE_WIDTH-1:0]          dataMem [2**BANK_INDEX_WIDTH];

  assign hit      = validBits[lookupIndex] && (tagMem[lookupIndex] == lookupTag);
  assign lineData = dataMem[lookupIndex];

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      validBits <= '0;
    end else if (fillValid) begin
      validBits[fillIndex] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clkIn) begin
    for (int b = 0; b < BLOCK_BYTES; b++) begin
      if (storeMask[b]) begin
        dataMem[lookupIndex][8*b +: 8] <= storeData[8*b +: 8];
      end
    end
    // a refill replaces the whole line, so it wins over any byte store
    if (fillValid) begin
      tagMem[fillIndex]  <= fillTag;
      dataMem[fillIndex] <= fillData;
    end
  end

  // no line is valid right after reset
  validClearAfterReset: assert property (
    @(posedge clkIn) resetIn |=> (validBits == '0)
  ) else $error("valid bits not clear after reset");

  // stores only reach lines that hit, refills never target a line in use
  noFillStoreClash: assert property (
    @(posedge clkIn) disable iff (resetIn)
    !(fillValid && (storeMask != '0) && (fillIndex == lookupIndex))
  ) else $error("refill and store to the same line");

endmodule

/* rtl/accessAlign.sv */
`timescale 1ns/100ps

// address split across banks, line merge, hit/miss decision, result registers
module accessAlign
  import dcachePkg::*;
(
  input  logic                        clkIn,
  input  logic                        resetIn,
  input  logic [1:0]                  accessType,
  input  logic                        readWriteIn,  // 1 is read
  input  logic [ADDR_WIDTH-1:0]       dataAddrIn,
  input  logic [31:0]                 dataIn,
  input  logic                        memDataValid,
  input  logic [BLOCK_ADDR_WIDTH-1:0] memAddr,
  input  logic [LINE_WIDTH-1:0]       memDataIn,
  input  logic                        evenHit,
  input  logic                        oddHit,
  input  logic [LINE_WIDTH-1:0]       evenLine,
  input  logic [LINE_WIDTH-1:0]       oddLine,
  output logic [BANK_INDEX_WIDTH-1:0] evenIndex,
  output logic [BANK_INDEX_WIDTH-1:0] oddIndex,
  output logic [TAG_WIDTH-1:0]        evenTag,
  output logic [TAG_WIDTH-1:0]        oddTag,
  output logic [BLOCK_BYTES-1:0]      evenStoreMask,
  output logic [BLOCK_BYTES-1:0]      oddStoreMask,
  output logic [LINE_WIDTH-1:0]       evenStoreData,
  output logic [LINE_WIDTH-1:0]       oddStoreData,
  output logic                        evenFillValid,
  output logic                        oddFillValid,
  output logic [BANK_INDEX_WIDTH-1:0] fillIndex,
  output logic [TAG_WIDTH-1:0]        fillTag,
  output logic [LINE_WIDTH-1:0]       fillData,
  output logic                        dataOutValid,
  output logic [31:0]                 dataOut,
  output logic                        dataWriteSuc,
  output logic                        miss,
  output logic [BLOCK_ADDR_WIDTH-1:0] missAddr
);

  dataAddrT reqAddr;
  dataAddrT nextAddr;
  dataAddrT fillAddr;

  logic                        request;
  logic                        firstOdd;    // first line sits in the odd bank
  logic [BLOCK_ADDR_WIDTH-1:0] firstBlock;
  logic [BLOCK_ADDR_WIDTH-1:0] secondBlock;
  logic [2:0]                  sizeBytes;
  logic [3:0]                  byteEnable;
  logic [OFFSET_WIDTH:0]       lastByte;
  logic                        crossing;
  logic                        firstHit;
  logic                        secondHit;
  logic                        allHit;
  logic                        storeOk;

  logic [LINE_WIDTH-1:0]       firstLine;
  logic [LINE_WIDTH-1:0]       secondLine;
  logic [2*LINE_WIDTH-1:0]     linePair;
  logic [31:0]                 readWord;
  logic [31:0]                 readValue;
  logic [2*BLOCK_BYTES-1:0]    pairMask;
  logic [2*LINE_WIDTH-1:0]     pairData;
  logic [BLOCK_BYTES-1:0]      firstMask;
  logic [BLOCK_BYTES-1:0]      secondMask;

  assign request = (accessType != ACCESS_NONE);

  // the two blocks an access can touch, last block wraps to 0
  assign reqAddr     = dataAddrIn;
  assign firstBlock  = reqAddr.block.blockAddr;
  assign secondBlock = firstBlock + 1'b1;
  assign nextAddr    = {secondBlock, {OFFSET_WIDTH{1'b0}}};
  assign firstOdd    = reqAddr.fields.index[0];

  assign evenIndex = firstOdd ? nextAddr.fields.index[INDEX_WIDTH-1:1]
                              : reqAddr.fields.index[INDEX_WIDTH-1:1];
  assign oddIndex  = firstOdd ? reqAddr.fields.index[INDEX_WIDTH-1:1]
                              : nextAddr.fields.index[INDEX_WIDTH-1:1];
  assign evenTag   = firstOdd ? nextAddr.fields.tag : reqAddr.fields.tag;
  assign oddTag    = firstOdd ? reqAddr.fields.tag : nextAddr.fields.tag;

  // refill path
  assign fillAddr      = {memAddr, {OFFSET_WIDTH{1'b0}}};
  assign fillIndex     = fillAddr.fields.index[INDEX_WIDTH-1:1];
  assign fillTag       = fillAddr.fields.tag;
  assign fillData      = memDataIn;
  assign evenFillValid = memDataValid && !fillAddr.fields.index[0];
  assign oddFillValid  = memDataValid && fillAddr.fields.index[0];

  always_comb begin
    case (accessType)
      ACCESS_BYTE: begin
        sizeBytes  = 3'd1;
        byteEnable = 4'b0001;
      end
      ACCESS_HALF: begin
        sizeBytes  = 3'd2;
        byteEnable = 4'b0011;
      end
      ACCESS_WORD: begin
        sizeBytes  = 3'd4;
        byteEnable = 4'b1111;
      end
      default: begin
        sizeBytes  = 3'd0;
        byteEnable = 4'b0000;
      end
    endcase
  end

  // carry out of the offset means the access runs into the next block
  assign lastByte = {1'b0, reqAddr.fields.offset} + (OFFSET_WIDTH+1)'(sizeBytes) - 1'b1;
  assign crossing = request && lastByte[OFFSET_WIDTH];

  assign firstHit  = firstOdd ? oddHit : evenHit;
  assign secondHit = firstOdd ? evenHit : oddHit;
  assign allHit    = firstHit && (!crossing || secondHit);
  assign storeOk   = request && !readWriteIn && allHit;

  // read side, little-endian across both lines
  assign firstLine  = firstOdd ? oddLine : evenLine;
  assign secondLine = firstOdd ? evenLine : oddLine;
  assign linePair   = {secondLine, firstLine};
  assign readWord   = linePair[{reqAddr.fields.offset, 3'b000} +: 32];

  always_comb begin
    case (accessType)
      ACCESS_BYTE: readValue = {24'b0, readWord[7:0]};
      ACCESS_HALF: readValue = {16'b0, readWord[15:0]};
      default:     readValue = readWord;
    endcase
  end

  // write side
  assign pairMask   = {{(2*BLOCK_BYTES-4){1'b0}}, byteEnable} << reqAddr.fields.offset;
  assign pairData   = {{(2*LINE_WIDTH-32){1'b0}}, dataIn} << {reqAddr.fields.offset, 3'b000};
  assign firstMask  = storeOk ? pairMask[BLOCK_BYTES-1:0] : '0;
  assign secondMask = storeOk ? pairMask[2*BLOCK_BYTES-1:BLOCK_BYTES] : '0;

  assign evenStoreMask = firstOdd ? secondMask : firstMask;
  assign oddStoreMask  = firstOdd ? firstMask : secondMask;
  assign evenStoreData = firstOdd ? pairData[2*LINE_WIDTH-1:LINE_WIDTH]
                                  : pairData[LINE_WIDTH-1:0];
  assign oddStoreData  = firstOdd ? pairData[LINE_WIDTH-1:0]
                                  : pairData[2*LINE_WIDTH-1:LINE_WIDTH];

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      dataOutValid <= 1'b0;
      dataWriteSuc <= 1'b0;
      miss         <= 1'b0;
    end else begin
      dataOutValid <= request && readWriteIn && allHit;
      dataWriteSuc <= storeOk;
      miss         <= request && !allHit;
    end
  end

  always_ff @(posedge clkIn) begin
    if (request) begin
      dataOut  <= readValue;
      missAddr <= firstHit ? secondBlock : firstBlock; // report the line that missed
    end
  end

  strobesExclusive: assert property (
    @(posedge clkIn) disable iff (resetIn)
    $onehot0({dataOutValid, dataWriteSuc, miss})
  ) else $error("more than one result strobe");

endmodule

/* rtl/dcacheTop.sv */
`timescale 1ns/100ps

// data cache top, even and odd banks side by side
module dcacheTop
  import dcachePkg::*;
(
  input  logic                        clkIn,
  input  logic                        resetIn,
  input  logic [1:0]                  accessType,
  input  logic                        readWriteIn,
  input  logic [ADDR_WIDTH-1:0]       dataAddrIn,
  input  logic [31:0]                 dataIn,
  input  logic                        memDataValid,
  input  logic [BLOCK_ADDR_WIDTH-1:0] memAddr,
  input  logic [LINE_WIDTH-1:0]       memDataIn,
  output logic                        dataOutValid,
  output logic [31:0]                 dataOut,
  output logic                        dataWriteSuc,
  output logic                        miss,
  output logic [BLOCK_ADDR_WIDTH-1:0] missAddr
);

  logic [BANK_INDEX_WIDTH-1:0] evenIndex;
  logic [BANK_INDEX_WIDTH-1:0] oddIndex;
  logic [TAG_WIDTH-1:0]        evenTag;
  logic [TAG_WIDTH-1:0]        oddTag;
  logic [BLOCK_BYTES-1:0]      evenStoreMask;
  logic [BLOCK_BYTES-1:0]      oddStoreMask;
  logic [LINE_WIDTH-1:0]       evenStoreData;
  logic [LINE_WIDTH-1:0]       oddStoreData;
  logic                        evenFillValid;
  logic                        oddFillValid;
  logic [BANK_INDEX_WIDTH-1:0] fillIndex;   // shared by both banks
  logic [TAG_WIDTH-1:0]        fillTag;
  logic [LINE_WIDTH-1:0]       fillData;
  logic                        evenHit;
  logic                        oddHit;
  logic [LINE_WIDTH-1:0]       evenLine;
  logic [LINE_WIDTH-1:0]       oddLine;

  cacheBank evenBank0 (
    .clkIn       (clkIn),
    .resetIn     (resetIn),
    .lookupIndex (evenIndex),
    .lookupTag   (evenTag),
    .storeMask   (evenStoreMask),
    .storeData   (evenStoreData),
    .fillValid   (evenFillValid),
    .fillIndex   (fillIndex),
    .fillTag     (fillTag),
    .fillData    (fillData),
    .hit         (evenHit),
    .lineData    (evenLine)
  );

  cacheBank oddBank0 (
    .clkIn       (clkIn),
    .resetIn     (resetIn),
    .lookupIndex (oddIndex),
    .lookupTag   (oddTag),
    .storeMask   (oddStoreMask),
    .storeData   (oddStoreData),
    .fillValid   (oddFillValid),
    .fillIndex   (fillIndex),
    .fillTag     (fillTag),
    .fillData    (fillData),
    .hit         (oddHit),
    .lineData    (oddLine)
  );

  accessAlign align0 (
    .clkIn         (clkIn),
    .resetIn       (resetIn),
    .accessType    (accessType),
    .readWriteIn   (readWriteIn),
    .dataAddrIn    (dataAddrIn),
    .dataIn        (dataIn),
    .memDataValid  (memDataValid),
    .memAddr       (memAddr),
    .memDataIn     (memDataIn),
    .evenHit       (evenHit),
    .oddHit        (oddHit),
    .evenLine      (evenLine),
    .oddLine       (oddLine),
    .evenIndex     (evenIndex),
    .oddIndex      (oddIndex),
    .evenTag       (evenTag),
    .oddTag        (oddTag),
    .evenStoreMask (evenStoreMask),
    .oddStoreMask  (oddStoreMask),
    .evenStoreData (evenStoreData),
    .oddStoreData  (oddStoreData),
    .evenFillValid (evenFillValid),
    .oddFillValid  (oddFillValid),
    .fillIndex     (fillIndex),
    .fillTag       (fillTag),
    .fillData      (fillData),
    .dataOutValid  (dataOutValid),
    .dataOut       (dataOut),
    .dataWriteSuc  (dataWriteSuc),
    .miss          (miss),
    .missAddr      (missAddr)
  );

endmodule

/* bench/clockGen.sv */
`timescale 1ns/100ps

// 10 ns clock, reset high over the first two rising edges
module clockGen (
  output logic clkIn,
  output logic resetIn
);

  initial begin
    clkIn = 1'b0;
    forever #5 clkIn = ~clkIn;
  end

  initial begin
    resetIn = 1'b1;
    repeat (2) @(posedge clkIn);
    @(negedge clkIn);  // release away from the sampling edge
    resetIn = 1'b0;
  end

endmodule

/* bench/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// cache contents, byte at index*16 + offset, i.e. address bits [8:0]
logic [7:0]           modelBytes [512];
logic                 modelValid [32];
logic [TAG_WIDTH-1:0] modelTag   [32];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic int byteCount(input logic [1:0] kind);
  case (kind)
    ACCESS_BYTE: return 1;
    ACCESS_HALF: return 2;
    ACCESS_WORD: return 4;
    default:     return 0;
  endcase
endfunction

function automatic logic lineHits(input logic [BLOCK_ADDR_WIDTH-1:0] blk);
  return modelValid[blk[INDEX_WIDTH-1:0]]
      && (modelTag[blk[INDEX_WIDTH-1:0]] == blk[BLOCK_ADDR_WIDTH-1:INDEX_WIDTH]);
endfunction

// {dataOutValid, dataWriteSuc, miss} then read data or miss block address
function automatic logic [34:0] expectedResult(input logic [1:0] kind, input logic isRead,
                                               input logic [ADDR_WIDTH-1:0] addr);
  dataAddrT                    a;
  logic [BLOCK_ADDR_WIDTH-1:0] blk;
  logic [BLOCK_ADDR_WIDTH-1:0] nextBlk;
  logic [ADDR_WIDTH-1:0]       byteAddr;
  logic [31:0]                 value;
  int                          n;
  int                          i;
  a       = addr;
  blk     = a.block.blockAddr;
  nextBlk = blk + 13'd1;  // wraps past the last block
  n       = byteCount(kind);
  value   = '0;
  if (!lineHits(blk)) return {3'b001, 19'b0, blk};
  if ((int'(a.fields.offset) + n > BLOCK_BYTES) && !lineHits(nextBlk)) begin
    return {3'b001, 19'b0, nextBlk};
  end
  if (!isRead) return {3'b010, 32'b0};
  for (i = 0; i < n; i++) begin
    byteAddr = addr + ADDR_WIDTH'(i);
    value[8*i +: 8] = modelBytes[byteAddr[8:0]];  // little-endian, zero above
  end
  return {3'b100, value};
endfunction

task automatic storeModel(input logic [1:0] kind, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [31:0] data);
  logic [ADDR_WIDTH-1:0] byteAddr;
  int                    i;
  for (i = 0; i < byteCount(kind); i++) begin
    byteAddr = addr + ADDR_WIDTH'(i);
    modelBytes[byteAddr[8:0]] = data[8*i +: 8];
  end
endtask

`endif

/* bench/tbTop.sv */
`timescale 1ns/100ps

module tbTop
  import dcachePkg::*;
#(
  parameter logic [31:0] randSeed = 32'heda08af9
);

  logic                        clkIn;
  logic                        resetIn;
  logic [1:0]                  accessType;
  logic                        readWriteIn;
  logic [ADDR_WIDTH-1:0]       dataAddrIn;
  logic [31:0]                 dataIn;
  logic                        memDataValid;
  logic [BLOCK_ADDR_WIDTH-1:0] memAddr;
  logic [LINE_WIDTH-1:0]       memDataIn;
  logic                        dataOutValid;
  logic [31:0]                 dataOut;
  logic                        dataWriteSuc;
  logic                        miss;
  logic [BLOCK_ADDR_WIDTH-1:0] missAddr;

  logic [31:0]                 rngState;
  logic [34:0]                 expQ [$];
  string                       nameQ [$];
  logic                        prevRequest;
  logic [2:0]                  cmpStrobes;
  logic [34:0]                 cmpExp;
  string                       cmpName;
  int                          failCount;
  logic [BLOCK_ADDR_WIDTH-1:0] baseBlk     = 13'h0a0;  // tag 5, index 0
  logic [BLOCK_ADDR_WIDTH-1:0] conflictBlk = 13'h125;  // tag 9, index 5

  `include "refModel.svh"

  clockGen clk0 (.*);
  dcacheTop dut0 (.*);

  function automatic logic [31:0] nextRandom();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  function automatic logic [LINE_WIDTH-1:0] randomLine();
    logic [LINE_WIDTH-1:0] line;
    int                    w;
    for (w = 0; w < LINE_WIDTH / 32; w++) begin
      line[32*w +: 32] = nextRandom();
    end
    return line;
  endfunction

  function automatic logic [1:0] randomKind(input logic [31:0] r);
    return (r[1:0] == ACCESS_NONE) ? ACCESS_WORD : r[1:0];
  endfunction

  // inside one of the 28 base lines, never crossing
  function automatic logic [ADDR_WIDTH-1:0] alignedAddr(input logic [31:0] r,
                                                        input logic [1:0] kind);
    int off;
    int line;
    off  = int'(r[11:8]) % (BLOCK_BYTES - byteCount(kind) + 1);
    line = int'(r[20:16]) % 28;
    return {baseBlk + BLOCK_ADDR_WIDTH'(line), OFFSET_WIDTH'(off)};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      failCount++;
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic failRun(input string what);
    $display("%s", what);
    failCount++;
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic idleCycle();
    @(negedge clkIn);
    accessType   = ACCESS_NONE;
    memDataValid = 1'b0;
  endtask

  task automatic refillLine(input logic [BLOCK_ADDR_WIDTH-1:0] blk,
                            input logic [LINE_WIDTH-1:0] line);
    dataAddrT a;
    int       b;
    @(negedge clkIn);
    accessType   = ACCESS_NONE;
    memDataValid = 1'b1;
    memAddr      = blk;
    memDataIn    = line;
    a = {blk, {OFFSET_WIDTH{1'b0}}};
    modelValid[a.fields.index] = 1'b1;
    modelTag[a.fields.index]   = a.fields.tag;
    for (b = 0; b < BLOCK_BYTES; b++) begin
      modelBytes[{a.fields.index, OFFSET_WIDTH'(b)}] = line[8*b +: 8];
    end
  endtask

  task automatic issueRequest(input string name, input logic [1:0] kind, input logic isRead,
                              input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] wdata);
    logic [34:0] expResult;
    @(negedge clkIn);
    expResult = expectedResult(kind, isRead, addr);
    expQ.push_back(expResult);
    nameQ.push_back(name);
    if (expResult[34:32] == 3'b010) storeModel(kind, addr, wdata);  // write hit lands
    memDataValid = 1'b0;
    accessType   = kind;
    readWriteIn  = isRead;
    dataAddrIn   = addr;
    dataIn       = wdata;
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (resetIn !== 1'b0) begin
      if (cycles == 10) failRun("reset was not released within 10 cycles");
      @(negedge clkIn);
      cycles++;
    end
  endtask

  task automatic waitForDrain();
    int cycles;
    cycles = 0;
    while (expQ.size() != 0) begin
      if (cycles == 20) failRun("results still outstanding after 20 cycles");
      @(negedge clkIn);
      cycles++;
    end
  endtask

  // results of the request seen on the previous edge
  always @(posedge clkIn) begin
    cmpStrobes = {dataOutValid, dataWriteSuc, miss};
    if (resetIn) begin
      prevRequest <= 1'b0;
    end else begin
      if (!prevRequest && (cmpStrobes !== 3'b000)) begin
        failRun("a result strobe came without a request");
      end
      if (prevRequest) begin
        if (expQ.size() == 0) failRun("a request left no expected result");
        cmpExp  = expQ.pop_front();
        cmpName = nameQ.pop_front();
        checkValue({cmpName, " strobes"}, 32'(cmpExp[34:32]), 32'(cmpStrobes));
        if (cmpStrobes == 3'b100) checkValue(cmpName, cmpExp[31:0], dataOut);
        if (cmpStrobes == 3'b001) checkValue({cmpName, " missAddr"}, cmpExp[31:0], 32'(missAddr));
      end
      prevRequest <= (accessType != ACCESS_NONE);
    end
  end

  initial begin
    logic [31:0]           r;
    logic [1:0]            kind;
    logic [ADDR_WIDTH-1:0] addr;
    int                    i;

    rngState     = randSeed;
    failCount    = 0;
    accessType   = ACCESS_NONE;
    readWriteIn  = 1'b0;
    dataAddrIn   = '0;
    dataIn       = '0;
    memDataValid = 1'b0;
    memAddr      = '0;
    memDataIn    = '0;
    for (i = 0; i < 32; i++) begin
      modelValid[i] = 1'b0;
    end
    waitForReset();
    repeat (3) idleCycle();  // quiet strobes after reset

    for (i = 0; i < 6; i++) begin
      r = nextRandom();
      issueRequest("cold miss", randomKind(r), r[31], r[16:0], 32'h0);
    end

    for (i = 0; i < 28; i++) begin
      refillLine(baseBlk + BLOCK_ADDR_WIDTH'(i), randomLine());
    end
    for (i = 0; i < 24; i++) begin
      r = nextRandom();
      kind = randomKind(r);
      issueRequest("refill read", kind, 1'b1, alignedAddr(r, kind), 32'h0);
    end

    for (i = 0; i < 24; i++) begin
      r = nextRandom();
      kind = randomKind(r);
      addr = alignedAddr(r, kind);
      issueRequest("write", kind, 1'b0, addr, nextRandom());
      issueRequest("read back", kind, 1'b1, addr, 32'h0);
      issueRequest("read back word", ACCESS_WORD, 1'b1, {addr[ADDR_WIDTH-1:2], 2'b00}, 32'h0);
    end
    // tag 9 not yet present at index 5 so the write must leave line 5 alone
    issueRequest("write miss", ACCESS_WORD, 1'b0, {conflictBlk, 4'd0}, 32'hdeadbeef);
    issueRequest("read after write miss", ACCESS_WORD, 1'b1, {baseBlk + 13'd5, 4'd0}, 32'h0);
    refillLine(baseBlk + 13'd28, randomLine());

    for (i = 0; i < 8; i++) begin
      r = nextRandom();
      kind = (i % 4 == 0) ? ACCESS_HALF : ACCESS_WORD;
      addr = {baseBlk + BLOCK_ADDR_WIDTH'(int'(r[20:16]) % 27),
              (i % 4 == 0) ? 4'd15 : OFFSET_WIDTH'(12 + i % 4)};
      issueRequest("crossing read", kind, 1'b1, addr, 32'h0);
      issueRequest("crossing write", kind, 1'b0, addr, nextRandom());
      issueRequest("crossing read back", kind, 1'b1, addr, 32'h0);
    end
    // line 29 absent
    issueRequest("second line miss", ACCESS_WORD, 1'b1, {baseBlk + 13'd28, 4'd14}, 32'h0);
    issueRequest("second line write miss", ACCESS_HALF, 1'b0, {baseBlk + 13'd28, 4'd15}, 32'h1234);
    issueRequest("first line unchanged", ACCESS_WORD, 1'b1, {baseBlk + 13'd28, 4'd12}, 32'h0);

    refillLine(conflictBlk, randomLine());
    issueRequest("evicted line", ACCESS_WORD, 1'b1, {baseBlk + 13'd5, 4'd0}, 32'h0);
    issueRequest("new line", ACCESS_WORD, 1'b1, {conflictBlk, 4'd4}, 32'h0);

    for (i = 0; i < 200; i++) begin
      r = nextRandom();
      addr = {(r[7:5] == 3'd0) ? 8'h09 : 8'h05, r[12:8], r[16:13]};
      issueRequest("back to back", randomKind(r), r[20], addr, nextRandom());
    end
    idleCycle();
    waitForDrain();

    if (failCount == 0 && expQ.size() == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "results missing at the end of the run");
    end
  end

endmodule

/* tb.f */
+incdir+bench
rtl/dcachePkg.sv
rtl/cacheBank.sv
rtl/accessAlign.sv
rtl/dcacheTop.sv
bench/clockGen.sv
bench/tbTop.sv

/* Makefile */
# Verilator build and run of the data cache testbench
SIM      ?= verilator
TOP      ?= tbTop
SEED     ?= 32'heda08af9
FILELIST ?= tb.f
BUILD    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: SIM TOP SEED FILELIST BUILD"

test:
	$(SIM) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f $(FILELIST) "-GrandSeed=$(SEED)" -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
